//--- bench/tb_udp_tx.sv
// udp transmit path testbench
module tb_udp_tx import net_pkg::*, frame_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LEN = 256;

  logic       tx_clock;
  logic       rst_n;
  logic       udp_tx_request;
  length_t    udp_tx_length;
  byte_t      udp_tx_data;
  logic       run;
  byte_t      port_id;
  endpoint_t  dest;
  mac_addr_t  local_mac;
  ip_addr_t   local_ip;
  logic       udp_tx_enable;
  logic       udp_tx_read;
  logic [3:0] PHY_TX;
  logic       PHY_TX_EN;

  logic [31:0] vec_mem [0:63];    // raw vector words
  byte_t       payload [0:MAX_LEN-1];
  int          cur_len;
  int          read_count;        // udp_tx_read pulses this frame
  byte_t       rx_bytes [$];      // reassembled frame
  int          en_cycles;
  logic        nib_phase;
  logic [3:0]  low_nib;
  logic        en_prev;
  logic        frame_done;
  logic        grant_seen;
  int          frames_sent;
  int          low_run;           // cycles since PHY_TX_EN was last high
  int          cycles;
  int          cycle_limit;
  integer      seed;
  endpoint_t   dest_a;
  endpoint_t   dest_b;

  udp_tx_top DUT (
    .tx_clock, .rst_n, .udp_tx_request, .udp_tx_length, .udp_tx_data, .run, .port_id,
    .dest, .local_mac, .local_ip, .udp_tx_enable, .udp_tx_read, .PHY_TX, .PHY_TX_EN
  );

  initial begin
    tx_clock = 1'b0;
    forever #50 tx_clock = ~tx_clock;
  end

  // --------------------------------------------------
  // failure reporting and compare
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare(input string name, input logic [47:0] exp, input logic [47:0] got);
    if (exp !== got)
      abort_run($sformatf("Mismatch %s exp=%h got=%h", name, exp, got));
  endtask

  // --------------------------------------------------
  // reference arithmetic
  // --------------------------------------------------
  function automatic int body_bytes(input int len);
    int b;
    b = len + MAC_HDR_BYTES + int'(IP_HDR_BYTES) + int'(UDP_HDR_BYTES);
    return (b < MIN_FRAME_BYTES) ? MIN_FRAME_BYTES : b;  // short frames padded
  endfunction

  // big endian field out of the received frame
  function automatic logic [47:0] field(input int idx, input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[39:0], rx_bytes[idx + i]};
    return v;
  endfunction

  // ones complement sum of ten words with the checksum word skipped
  function automatic logic [15:0] header_checksum(input int base);
    logic [31:0] acc;
    acc = '0;
    for (int w = 0; w < 10; w++) begin
      if (w != 5)
        acc = acc + {16'h0, rx_bytes[base + 2*w], rx_bytes[base + 2*w + 1]};
    end
    while (acc[31:16] != 0)
      acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};  // end-around carry
    return ~acc[15:0];
  endfunction

  // bitwise ethernet crc32 taking each byte lsb first
  function automatic logic [31:0] crc_step(input logic [31:0] c, input byte_t d);
    logic fb;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ d[i];
      c  = {1'b0, c[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
    end
    return c;
  endfunction

  // --------------------------------------------------
  // monitor sampling on the rising edge
  // --------------------------------------------------
  always @(posedge tx_clock) begin
    if (!rst_n) begin
      en_prev     = 1'b0;
      nib_phase   = 1'b0;
      frame_done  = 1'b0;
      frames_sent = 0;
      low_run     = 0;
      en_cycles   = 0;
      read_count  = 0;
    end else begin
      if (udp_tx_enable) begin
        if (frames_sent > 0 && low_run < 2 * IFG_BYTES)
          abort_run($sformatf("grant came after only %0d idle line cycles", low_run));
        rx_bytes.delete();
        en_cycles  = 0;
        nib_phase  = 1'b0;
        frame_done = 1'b0;
        read_count = 0;
        grant_seen = 1'b1;
      end
      if (udp_tx_read)
        read_count++;
      if (PHY_TX_EN) begin
        if (nib_phase)
          rx_bytes.push_back({PHY_TX, low_nib});  // high nibble completes the byte
        else
          low_nib = PHY_TX;
        nib_phase = !nib_phase;
        en_cycles++;
        low_run = 0;
      end else begin
        low_run++;
        if (en_prev) begin
          frame_done = 1'b1;  // falling PHY_TX_EN
          frames_sent++;
        end
      end
      en_prev = PHY_TX_EN;
    end
  end

  always @(posedge tx_clock) begin
    cycles++;
    if (cycles > cycle_limit)
      abort_run($sformatf("no frame ended in time, gave up after %0d cycles", cycles));
  end

  // payload source advancing after each read pulse
  always @(negedge tx_clock)
    udp_tx_data = (read_count < cur_len) ? payload[read_count] : 8'h00;

  task automatic send_frame(input int len);
    udp_tx_length  = length_t'(len);
    cur_len        = len;
    grant_seen     = 1'b0;
    udp_tx_request = 1'b1;
    while (!grant_seen)
      @(negedge tx_clock);
    udp_tx_request = 1'b0;  // dropped once the grant was seen
    while (!frame_done)
      @(negedge tx_clock);
  endtask

  task automatic check_frame(input int t, input int len, input endpoint_t exp_dest,
                             input logic [15:0] exp_csum, input logic [31:0] exp_residue);
    int          body;
    int          ip;
    int          udp;
    int          fcs;
    logic [31:0] crc;
    body = body_bytes(len);
    ip   = PREAMBLE_BYTES + MAC_HDR_BYTES;
    udp  = ip + int'(IP_HDR_BYTES);
    fcs  = PREAMBLE_BYTES + body;
    compare("frame bytes", fcs + FCS_BYTES, rx_bytes.size());
    compare("PHY_TX_EN cycles", 2 * (fcs + FCS_BYTES), en_cycles);
    compare("udp_tx_read pulses", len, read_count);
    for (int i = 0; i < PREAMBLE_BYTES; i++)
      compare("preamble", (i == PREAMBLE_BYTES - 1) ? 8'hD5 : 8'h55, rx_bytes[i]);
    compare("dest mac", exp_dest.mac, field(PREAMBLE_BYTES, 6));
    compare("source mac", local_mac, field(PREAMBLE_BYTES + 6, 6));
    compare("ethertype", 16'h0800, field(PREAMBLE_BYTES + 12, 2));
    // ip header
    compare("ip version tos", 16'h4500, field(ip, 2));
    compare("ip total length", len + IP_HDR_BYTES + UDP_HDR_BYTES, field(ip + 2, 2));
    compare("ip identification", t, field(ip + 4, 2));  // one per frame from reset
    compare("ip flags", 16'h4000, field(ip + 6, 2));
    compare("ip ttl protocol", {IP_TTL, IP_PROTO_UDP}, field(ip + 8, 2));
    compare("ip checksum rule", header_checksum(ip), field(ip + 10, 2));
    compare("ip checksum vector", exp_csum, field(ip + 10, 2));
    compare("ip source", local_ip, field(ip + 12, 4));
    compare("ip destination", exp_dest.ip, field(ip + 16, 4));
    // udp header and payload
    compare("udp source port", UDP_BASE_PORT + port_id, field(udp, 2));
    compare("udp dest port", exp_dest.port, field(udp + 2, 2));
    compare("udp length", len + UDP_HDR_BYTES, field(udp + 4, 2));
    compare("udp checksum", 16'h0000, field(udp + 6, 2));
    for (int i = 0; i < len; i++)
      compare($sformatf("payload[%0d]", i), payload[i], rx_bytes[udp + 8 + i]);
    for (int i = udp + 8 + len; i < fcs; i++)
      compare("pad byte", 8'h00, rx_bytes[i]);
    // fcs over dest mac to last pad byte
    crc = 32'hFFFF_FFFF;
    for (int i = PREAMBLE_BYTES; i < fcs; i++)
      crc = crc_step(crc, rx_bytes[i]);
    compare("fcs", {16'h0, ~crc}, {rx_bytes[fcs + 3], rx_bytes[fcs + 2],
                                   rx_bytes[fcs + 1], rx_bytes[fcs]});
    for (int i = fcs; i < fcs + FCS_BYTES; i++)
      crc = crc_step(crc, rx_bytes[i]);
    compare("crc residue vector", exp_residue, crc);
    $display("frame %0d ok, %0d payload bytes", t, len);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int          ntests;
    int          ptr;
    int          len;
    int          given;
    logic [15:0] exp_csum;
    logic [31:0] exp_residue;
    seed   = 14860;
    cycles = 0;
    dest_a = '{mac: 48'h0200_0000_0020, ip: 32'hC0A8_0114, port: 16'd5000};
    dest_b = '{mac: 48'h0A1B_2C3D_4E5F, ip: 32'h0A00_0005, port: 16'd7777};
    rst_n          = 1'b0;
    run            = 1'b0;
    udp_tx_request = 1'b0;
    udp_tx_length  = '0;
    udp_tx_data    = '0;
    port_id        = 8'h2A;
    dest           = dest_a;
    local_mac      = 48'h0212_3456_789A;
    local_ip       = 32'hC0A8_010A;
    cur_len        = 0;

    $readmemh("bench/udp_tx_vectors.txt", vec_mem);
    ntests = vec_mem[0];
    cycle_limit = 20;  // reset and first grant
    ptr = 1;
    for (int t = 0; t < ntests; t++) begin
      cycle_limit += 2 * (PREAMBLE_BYTES + body_bytes(vec_mem[ptr]) + FCS_BYTES + IFG_BYTES) + 8;
      ptr += vec_mem[ptr + 1] + 4;
    end
    cycle_limit *= 2;

    repeat (2) @(posedge tx_clock);
    @(negedge tx_clock);
    rst_n = 1'b1;
    run   = 1'b1;  // dest_a frozen from here

    ptr = 1;
    for (int t = 0; t < ntests; t++) begin
      len         = vec_mem[ptr];
      given       = vec_mem[ptr + 1];
      exp_csum    = vec_mem[ptr + 2 + given][15:0];
      exp_residue = vec_mem[ptr + 3 + given];
      for (int i = 0; i < len; i++)
        payload[i] = (given != 0) ? vec_mem[ptr + 2 + i][7:0] : byte_t'($random(seed));
      ptr += given + 4;
      if (t == 2)
        dest = dest_b;  // run still high so this must not show up yet
      if (t == 3) begin
        run = 1'b0;
        repeat (2) @(negedge tx_clock);
        run = 1'b1;
      end
      send_frame(len);
      check_frame(t, len, (t < 3) ? dest_a : dest_b, exp_csum, exp_residue);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

//--- bench/udp_tx_vectors.txt
// per test: payload length, count of listed bytes (0 = random fill), listed bytes,
// expected ip header checksum, expected crc32 residue over body and fcs (all hex)
// first word is the number of tests
4
// 32-byte payload, random fill
20 0 7742 debb20e3
// 4-byte payload, padded to the minimum frame
4 4 de ad be ef 775d debb20e3
// 46 bytes, dest changed while run is high
2e 0 7732 debb20e3
// 20 bytes, new destination after run drops
14 0 2f03 debb20e3

//--- hdl/eth_framer.sv
// ethernet framing, padding and fcs
module eth_framer import net_pkg::*, frame_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      start,
  input  mac_addr_t local_mac,
  input  mac_addr_t dest_mac,
  input  stream_t   in_byte,     // ip stream
  input  logic      next,        // pull from mii
  output logic      in_next,
  output stream_t   out_byte
);

  eth_state_t   state;
  length_t      cnt;        // preamble index, body index, then fcs index
  logic [31:0]  crc;        // reflected running remainder
  mac_addr_t    dst_mac;
  logic [111:0] hdr;        // dest mac, source mac, ethertype
  logic         body_pull;

  // one byte through the reflected crc32, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
    logic [31:0] r;
    logic [31:0] poly_r;
    poly_r = {<<{CRC_POLY}};
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ poly_r) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge tx_clock) begin
    if (start)
      dst_mac <= dest_mac;
  end

  assign hdr       = {dst_mac, local_mac, ETHERTYPE_IPV4};
  assign body_pull = next && (state inside {ETH_HDR, ETH_DATA, ETH_PAD});  // fcs span
  assign in_next   = next && (state == ETH_DATA);

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state <= ETH_IDLE;
      cnt   <= '0;
      crc   <= '1;
    end else begin
      if (start)
        crc <= '1;
      else if (body_pull)
        crc <= crc_byte(crc, out_byte.data);  // same cycle as consumption

      case (state)
        ETH_IDLE: if (start) begin
          state <= ETH_PRE;
          cnt   <= '0;
        end
        ETH_PRE: if (next) begin
          if (cnt == PREAMBLE_BYTES - 1) begin
            state <= ETH_HDR;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ETH_HDR: if (next) begin
          if (cnt == MAC_HDR_BYTES - 1)
            state <= ETH_DATA;
          cnt <= cnt + 1'b1;   // keeps counting body bytes
        end
        ETH_DATA: if (next) begin
          cnt <= cnt + 1'b1;
          if (in_byte.last) begin
            if (cnt < MIN_FRAME_BYTES - 1) begin
              state <= ETH_PAD;  // short frame
            end else begin
              state <= ETH_FCS;
              cnt   <= '0;
            end
          end
        end
        ETH_PAD: if (next) begin
          if (cnt == MIN_FRAME_BYTES - 1) begin
            state <= ETH_FCS;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ETH_FCS: if (next) begin
          if (cnt == FCS_BYTES - 1)
            state <= ETH_IDLE;
          cnt <= cnt + 1'b1;
        end
        default: state <= ETH_IDLE;
      endcase
    end
  end

  always_comb begin
    out_byte = '0;
    case (state)
      ETH_PRE: begin
        out_byte.data  = (cnt == PREAMBLE_BYTES - 1) ? SFD_BYTE : PREAMBLE_BYTE;
        out_byte.first = (cnt == '0);
      end
      ETH_HDR:  out_byte.data = hdr[8*(MAC_HDR_BYTES - 1 - int'(cnt)) +: 8];
      ETH_DATA: out_byte.data = in_byte.data;
      ETH_PAD:  out_byte.data = 8'h00;
      ETH_FCS: begin
        out_byte.data = ~crc[8*int'(cnt[1:0]) +: 8];  // lsb byte first
        out_byte.last = (cnt == FCS_BYTES - 1);
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/frame_pkg.sv
// byte stream and ethernet framing definitions
package frame_pkg;

  typedef logic [7:0] byte_t;

  // one byte handed down the framer chain
  typedef struct packed {
    byte_t data;
    logic  first;  // first byte of this layer
    logic  last;   // last byte of this layer
  } stream_t;

  // --------------------------------------------------
  // ethernet framing
  // --------------------------------------------------
  localparam int         PREAMBLE_BYTES  = 8;      // includes the SFD
  localparam byte_t      PREAMBLE_BYTE   = 8'h55;
  localparam byte_t      SFD_BYTE        = 8'hD5;
  localparam int         MAC_HDR_BYTES   = 14;
  localparam int         MIN_FRAME_BYTES = 60;     // body without FCS
  localparam int         FCS_BYTES       = 4;
  localparam int         IFG_BYTES       = 12;
  localparam logic [31:0] CRC_POLY       = 32'h04C11DB7;  // used bit reversed

  // framer phases
  typedef enum logic [1:0] {UDP_IDLE, UDP_HDR, UDP_DATA} udp_state_t;
  typedef enum logic [1:0] {IP_IDLE, IP_HDR, IP_DATA} ip_state_t;
  typedef enum logic [2:0] {
    ETH_IDLE, ETH_PRE, ETH_HDR, ETH_DATA, ETH_PAD, ETH_FCS
  } eth_state_t;

endpackage

//--- hdl/ipv4_framer.sv
// ipv4 header insertion with header checksum
module ipv4_framer import net_pkg::*, frame_pkg::*; (
  input  logic     tx_clock,
  input  logic     rst_n,
  input  logic     start,
  input  ip_addr_t local_ip,
  input  ip_addr_t dest_ip,
  input  length_t  payload_length,   // user payload, without udp header
  input  stream_t  in_byte,          // udp stream
  input  logic     next,
  output logic     in_next,
  output stream_t  out_byte
);

  ip_state_t    state;
  length_t      cnt;         // header byte index
  length_t      total_len;
  logic [15:0]  ident;       // bumps once per frame
  ip_addr_t     src_ip;
  ip_addr_t     dst_ip;
  logic [159:0] hdr_base;    // checksum field zero
  logic [159:0] hdr_tx;      // checksum filled in
  logic [3:0]   sum_idx;     // sequencer word index
  logic [15:0]  sum;         // end-around-carry accumulator
  logic [15:0]  sum_word;
  logic [16:0]  sum_raw;
  logic         sum_done;

  // header fields fixed for the whole frame
  always_ff @(posedge tx_clock) begin
    if (start) begin
      total_len <= payload_length + IP_HDR_BYTES + UDP_HDR_BYTES;
      src_ip    <= local_ip;
      dst_ip    <= dest_ip;
    end
  end

  assign hdr_base = {8'h45, 8'h00, total_len, ident,
                     16'h4000,                       // don't fragment
                     IP_TTL, IP_PROTO_UDP, 16'h0000,
                     src_ip, dst_ip};
  assign hdr_tx   = hdr_base | {80'h0, ~sum, 64'h0};

  // --------------------------------------------------
  // checksum sequencer, one word per cycle
  // --------------------------------------------------
  assign sum_word = hdr_base[16*(int'(IP_HDR_BYTES / 2) - 1 - int'(sum_idx)) +: 16];
  assign sum_raw  = {1'b0, sum} + {1'b0, sum_word};
  assign sum_done = (sum_idx == 4'(IP_HDR_BYTES / 2));

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state   <= IP_IDLE;
      cnt     <= '0;
      ident   <= '0;
      sum     <= '0;
      sum_idx <= 4'(IP_HDR_BYTES / 2);  // parked as done
    end else begin
      if (start) begin
        sum     <= '0;
        sum_idx <= '0;
      end else if (!sum_done) begin
        sum     <= sum_raw[15:0] + 16'(sum_raw[16]);  // fold carry back in
        sum_idx <= sum_idx + 1'b1;
      end

      case (state)
        IP_IDLE: if (start) begin
          state <= IP_HDR;
          cnt   <= '0;
        end
        IP_HDR: if (next) begin
          if (cnt == IP_HDR_BYTES - 1'b1)
            state <= IP_DATA;
          cnt <= cnt + 1'b1;
        end
        IP_DATA: if (next && in_byte.last) begin
          state <= IP_IDLE;
          ident <= ident + 1'b1;  // next frame's id
        end
        default: state <= IP_IDLE;
      endcase
    end
  end

  always_comb begin
    out_byte = '0;
    case (state)
      IP_HDR: begin
        out_byte.data  = hdr_tx[8*(int'(IP_HDR_BYTES) - 1 - int'(cnt)) +: 8];
        out_byte.first = (cnt == '0);
      end
      IP_DATA: begin
        out_byte.data = in_byte.data;  // udp datagram as payload
        out_byte.last = in_byte.last;
      end
      default: ;
    endcase
  end

  assign in_next = next && (state == IP_DATA);

  // mac preamble and header give the sequencer far more than ten cycles
  a_csum_before_use: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (state == IP_HDR && cnt == 16'd10 && next) |-> sum_done);

endmodule

//--- hdl/mii_tx.sv
// mii nibble transmitter
module mii_tx import frame_pkg::*; (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  stream_t    in_byte,
  input  logic       frame_go,   // start of frame
  output logic       next_byte,  // consume in_byte
  output logic       ready,      // idle, gap done
  output logic [3:0] PHY_TX,
  output logic       PHY_TX_EN
);

  logic       sending;
  logic       phase;     // 0 low nibble, 1 high nibble
  logic       last_r;    // current byte ends the frame
  logic [3:0] hi_nib;
  logic [5:0] gap_cnt;   // interframe gap, in cycles

  assign next_byte = sending && !phase;

  // nibble data path
  always_ff @(posedge tx_clock) begin
    if (next_byte) begin
      PHY_TX <= in_byte.data[3:0];
      hi_nib <= in_byte.data[7:4];
    end else if (sending) begin
      PHY_TX <= hi_nib;
    end
  end

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      sending   <= 1'b0;
      phase     <= 1'b0;
      last_r    <= 1'b0;
      ready     <= 1'b0;
      gap_cnt   <= '0;
      PHY_TX_EN <= 1'b0;
    end else if (frame_go) begin
      sending <= 1'b1;
      phase   <= 1'b0;
      last_r  <= 1'b0;
      ready   <= 1'b0;
    end else if (sending) begin
      phase     <= !phase;
      PHY_TX_EN <= 1'b1;
      if (!phase) begin
        last_r <= in_byte.last;
      end else if (last_r) begin
        sending <= 1'b0;
        gap_cnt <= 6'(IFG_BYTES * 2);  // two nibbles per gap byte
      end
    end else begin
      PHY_TX_EN <= 1'b0;
      if (gap_cnt != '0)
        gap_cnt <= gap_cnt - 1'b1;
      else
        ready <= 1'b1;
    end
  end

  a_gap_kept: assert property (@(posedge tx_clock) disable iff (!rst_n)
    $rose(PHY_TX_EN) |-> ($past(gap_cnt) == '0));

endmodule

//--- hdl/net_pkg.sv
// network address and protocol header definitions
package net_pkg;

  // --------------------------------------------------
  // address, port and count types
  // --------------------------------------------------
  typedef logic [47:0] mac_addr_t;  // ethernet station address
  typedef logic [31:0] ip_addr_t;   // ipv4 address, network order
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] length_t;    // byte count

  // where a frame goes, carried as one group
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
  } endpoint_t;

  // --------------------------------------------------
  // udp header
  // --------------------------------------------------
  // source port = base + port_id
  localparam udp_port_t UDP_BASE_PORT = 16'd1024;
  localparam length_t   UDP_HDR_BYTES = 16'd8;

  // --------------------------------------------------
  // ipv4 header
  // --------------------------------------------------
  // no options, so IHL is always 5
  localparam length_t    IP_HDR_BYTES = 16'd20;
  localparam logic [7:0] IP_TTL       = 8'd128;
  localparam logic [7:0] IP_PROTO_UDP = 8'd17;

  // --------------------------------------------------
  // ethernet
  // --------------------------------------------------
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

endpackage

//--- hdl/udp_framer.sv
// udp header insertion
module udp_framer import net_pkg::*, frame_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      start,           // frame start strobe
  input  logic      run,
  input  endpoint_t dest,
  input  byte_t     port_id,
  input  length_t   payload_length,
  input  byte_t     payload,
  input  logic      next,            // pull from ip framer
  output logic      payload_read,    // pull toward user
  output stream_t   out_byte,
  output endpoint_t dest_held
);

  udp_state_t  state;
  length_t     cnt;        // header index, later payload index
  length_t     len;        // payload length of this frame
  udp_port_t   src_port;
  length_t     udp_len;
  logic [63:0] hdr;        // src port, dst port, length, checksum

  // destination tracks the input until run is set
  always_ff @(posedge tx_clock) begin
    if (!run)
      dest_held <= dest;
  end

  always_ff @(posedge tx_clock) begin
    if (start)
      len <= payload_length;
  end

  assign src_port = UDP_BASE_PORT + {8'h00, port_id};
  assign udp_len  = len + UDP_HDR_BYTES;
  assign hdr      = {src_port, dest_held.port, udp_len, 16'h0000};  // no udp checksum

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state <= UDP_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        UDP_IDLE: if (start) begin
          state <= UDP_HDR;
          cnt   <= '0;
        end
        UDP_HDR: if (next) begin
          if (cnt == UDP_HDR_BYTES - 1'b1) begin
            state <= (len == '0) ? UDP_IDLE : UDP_DATA;  // empty payload ends here
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        UDP_DATA: if (next) begin
          if (cnt == len - 1'b1)
            state <= UDP_IDLE;
          cnt <= cnt + 1'b1;
        end
        default: state <= UDP_IDLE;
      endcase
    end
  end

  always_comb begin
    out_byte = '0;
    case (state)
      UDP_HDR: begin
        out_byte.data  = hdr[8*(7 - int'(cnt)) +: 8];  // msb first
        out_byte.first = (cnt == '0);
        out_byte.last  = (cnt == UDP_HDR_BYTES - 1'b1) && (len == '0);
      end
      UDP_DATA: begin
        out_byte.data = payload;           // straight from user
        out_byte.last = (cnt == len - 1'b1);
      end
      default: ;
    endcase
  end

  assign payload_read = next && (state == UDP_DATA);

  // ip framer stops pulling once the last byte is gone
  a_no_pull_when_idle: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (state == UDP_IDLE) |-> !next);

endmodule

//--- hdl/udp_tx_top.sv
// udp transmit path to mii
module udp_tx_top import net_pkg::*, frame_pkg::*; (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  logic       udp_tx_request,
  input  length_t    udp_tx_length,
  input  byte_t      udp_tx_data,
  input  logic       run,
  input  byte_t      port_id,
  input  endpoint_t  dest,
  input  mac_addr_t  local_mac,
  input  ip_addr_t   local_ip,
  output logic       udp_tx_enable,
  output logic       udp_tx_read,
  output logic [3:0] PHY_TX,
  output logic       PHY_TX_EN
);

  stream_t   udp_byte;
  stream_t   ip_byte;
  stream_t   eth_byte;
  logic      udp_pull;    // ip -> udp
  logic      ip_pull;     // eth -> ip
  logic      mii_pull;    // mii -> eth
  logic      mii_ready;
  endpoint_t dest_held;

  // grant only when the line is idle and the gap is over
  assign udp_tx_enable = mii_ready && udp_tx_request;

  udp_framer udp_framer_inst (
    .tx_clock, .rst_n, .start(udp_tx_enable), .run, .dest, .port_id,
    .payload_length(udp_tx_length), .payload(udp_tx_data), .next(udp_pull),
    .payload_read(udp_tx_read), .out_byte(udp_byte), .dest_held
  );

  ipv4_framer ipv4_framer_inst (
    .tx_clock, .rst_n, .start(udp_tx_enable), .local_ip, .dest_ip(dest_held.ip),
    .payload_length(udp_tx_length), .in_byte(udp_byte), .next(ip_pull),
    .in_next(udp_pull), .out_byte(ip_byte)
  );

  eth_framer eth_framer_inst (
    .tx_clock, .rst_n, .start(udp_tx_enable), .local_mac, .dest_mac(dest_held.mac),
    .in_byte(ip_byte), .next(mii_pull), .in_next(ip_pull), .out_byte(eth_byte)
  );

  mii_tx mii_tx_inst (
    .tx_clock, .rst_n, .in_byte(eth_byte), .frame_go(udp_tx_enable),
    .next_byte(mii_pull), .ready(mii_ready), .PHY_TX, .PHY_TX_EN
  );

endmodule

//--- project.f
hdl/net_pkg.sv
hdl/frame_pkg.sv
hdl/udp_framer.sv
hdl/ipv4_framer.sv
hdl/eth_framer.sv
hdl/mii_tx.sv
hdl/udp_tx_top.sv
bench/tb_udp_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the udp transmit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_udp_tx -f project.f -o sim_udp_tx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_udp_tx)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
exit 1
